// File: verilog/xaui_infra_pkg.sv
`default_nettype none

package xaui_infra_pkg;

  // Each XAUI port is carried on four transceiver lanes
  localparam int lanes_per_port = 4;

  // Extra cycles the PMA reset is held once the system reset is released
  localparam int pma_hold_cycles = 4;

  // Raw receive indications of one transceiver lane, two bytes per word
  typedef struct packed {
    logic [15:0] data;
    logic [1:0]  charisk;
    logic [1:0]  comma;
    logic [1:0]  disperr;
    logic [1:0]  notintable;
    logic [1:0]  lossofsync;  // bit 1 high means the lane holds sync
    logic        bufstatus;
    logic        elecidle;
    logic        lock;
  } gtx_lane_raw_t;

  // Decoded record of one lane as seen by the XAUI core
  typedef struct packed {
    logic [15:0] data;
    logic [1:0]  charisk;
    logic [1:0]  comma;
    logic [1:0]  codevalid;
    logic        syncok;
    logic        bufferr;
    logic        elecidle;
    logic        lock;
  } lane_rx_t;

  // Summary of one port
  typedef struct packed {
    logic [15:0] status;
    logic        link_up;
  } port_status_t;

  // PMA reset sequencer states
  typedef enum logic [1:0] {
    rst_hold,
    rst_count,
    rst_run
  } reset_state_e;

endpackage

`default_nettype wire

// File: verilog/pma_reset_seq.sv
`default_nettype none

module pma_reset_seq
  import xaui_infra_pkg::*;
(
  input  wire logic gtx_refclk_bufr,
  input  wire logic mgt_reset,
  output logic      pma_reset
);

  // Wide enough to hold the full count even when it is a power of two
  localparam int cnt_w = $clog2(pma_hold_cycles + 1);

  reset_state_e     state;
  logic [cnt_w-1:0] hold_cnt;

  always_ff @(posedge gtx_refclk_bufr) begin
    if (mgt_reset) begin
      state    <= rst_hold;
      hold_cnt <= '0;
    end else begin
      case (state)
        rst_hold: begin
          // First edge with the system reset low, start the stretch
          state    <= rst_count;
          hold_cnt <= cnt_w'(pma_hold_cycles - 1);
        end
        rst_count: begin
          if (hold_cnt == '0) begin
            state <= rst_run;
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end
        rst_run: begin
          state <= rst_run;
        end
        default: begin
          state <= rst_hold;
        end
      endcase
    end
  end

  // The transceiver PLLs and datapath stay in reset until the run state
  assign pma_reset = (state != rst_run);

  // The PMA reset is released only once the system reset has been low for
  // the release edge and the whole hold count
  a_hold_length: assert property (
    @(posedge gtx_refclk_bufr) $fell(pma_reset) |-> !$past(mgt_reset, pma_hold_cycles + 1)
  ) else $error("pma_reset fell before the hold count ran out");

endmodule

`default_nettype wire

// File: verilog/lane_status_decode.sv
`default_nettype none

module lane_status_decode
  import xaui_infra_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input  wire logic          gtx_refclk_bufr,
  input  wire logic          pma_reset,
  input  wire gtx_lane_raw_t lane_raw [NUM_PORTS*lanes_per_port],
  output lane_rx_t           lane_dec [NUM_PORTS*lanes_per_port]
);

  localparam int num_lanes = NUM_PORTS * lanes_per_port;

  lane_rx_t lane_next [num_lanes];

  // Turn the 8b10b error flags and the loss-of-sync state into plain
  // per-byte valid bits and a single sync indication
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      lane_next[l].data      = lane_raw[l].data;
      lane_next[l].charisk   = lane_raw[l].charisk;
      lane_next[l].comma     = lane_raw[l].comma;
      lane_next[l].codevalid = ~(lane_raw[l].disperr | lane_raw[l].notintable);
      lane_next[l].syncok    = lane_raw[l].lossofsync[1];
      lane_next[l].bufferr   = lane_raw[l].bufstatus;
      lane_next[l].elecidle  = lane_raw[l].elecidle;
      lane_next[l].lock      = lane_raw[l].lock;
    end
  end

  // The transceiver outputs are meaningless during PMA reset, so the
  // records are held at zero until it is released
  always_ff @(posedge gtx_refclk_bufr) begin
    for (int l = 0; l < num_lanes; l++) begin
      if (pma_reset) begin
        lane_dec[l] <= '0;
      end else begin
        lane_dec[l] <= lane_next[l];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/rx_lane_steer.sv
`default_nettype none

module rx_lane_steer
  import xaui_infra_pkg::*;
#(
  parameter int NUM_PORTS  = 2,
  parameter     LANE_STEER = 0
) (
  input  wire logic                                gtx_refclk_bufr,
  input  wire logic                                pma_reset,
  input  wire lane_rx_t                            lane_dec [NUM_PORTS*lanes_per_port],
  input  wire logic [NUM_PORTS*lanes_per_port-1:0] rxencommaalign,
  output lane_rx_t                                 lane_rx [NUM_PORTS*lanes_per_port],
  output logic [NUM_PORTS*lanes_per_port-1:0]      encommaalign_phys
);

  localparam int num_lanes = NUM_PORTS * lanes_per_port;

  // A steer bit beyond the last port would point at lanes that do not exist
  if ((LANE_STEER >> NUM_PORTS) != 0) begin : g_bad_steer
    $error("LANE_STEER has bits set above NUM_PORTS");
  end

  if (NUM_PORTS < 1 || NUM_PORTS > 8) begin : g_bad_ports
    $error("NUM_PORTS must be between 1 and 8");
  end

  // Physical lane feeding a logical lane. The reversal undoes a crossover
  // at the link partner and is its own inverse, so the same map serves
  // both directions
  function automatic int phys_index(input int port, input int lane);
    int offset;
    offset = LANE_STEER[port] ? (lanes_per_port - 1 - lane) : lane;
    return port * lanes_per_port + offset;
  endfunction

  lane_rx_t lane_steered [num_lanes];

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int k = 0; k < lanes_per_port; k++) begin
        lane_steered[p*lanes_per_port + k] = lane_dec[phys_index(p, k)];
      end
    end
  end

  always_ff @(posedge gtx_refclk_bufr) begin
    for (int l = 0; l < num_lanes; l++) begin
      if (pma_reset) begin
        lane_rx[l] <= '0;
      end else begin
        lane_rx[l] <= lane_steered[l];
      end
    end
  end

  // Comma-align enables go straight back to the transceiver lanes
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int k = 0; k < lanes_per_port; k++) begin
        encommaalign_phys[phys_index(p, k)] = rxencommaalign[p*lanes_per_port + k];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/port_status_result.sv
`default_nettype none

module port_status_result
  import xaui_infra_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input  wire logic     gtx_refclk_bufr,
  input  wire logic     pma_reset,
  input  wire lane_rx_t lane_rx [NUM_PORTS*lanes_per_port],
  output port_status_t  port_status [NUM_PORTS]
);

  port_status_t status_next [NUM_PORTS];

  // Status word layout is 4'b0, bufferr[3:0], 4'b0, elecidle[3:0]
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      status_next[p].status  = '0;
      status_next[p].link_up = 1'b1;
      for (int k = 0; k < lanes_per_port; k++) begin
        status_next[p].status[8 + k] = lane_rx[p*lanes_per_port + k].bufferr;
        status_next[p].status[k]     = lane_rx[p*lanes_per_port + k].elecidle;
        // Every lane has to be locked, in sync and decoding clean bytes
        status_next[p].link_up = status_next[p].link_up
                               & lane_rx[p*lanes_per_port + k].syncok
                               & lane_rx[p*lanes_per_port + k].lock
                               & (&lane_rx[p*lanes_per_port + k].codevalid);
      end
    end
  end

  always_ff @(posedge gtx_refclk_bufr) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (pma_reset) begin
        port_status[p] <= '0;
      end else begin
        port_status[p] <= status_next[p];
      end
    end
  end

  // The PMA reset clears three register stages, so the link cannot be
  // reported up until the reset has been low long enough to refill them
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_chk
    a_no_link_in_reset: assert property (
      @(posedge gtx_refclk_bufr)
        port_status[p].link_up |-> !$past(pma_reset, 1) && !$past(pma_reset, 2)
                                   && !$past(pma_reset, 3)
    ) else $error("port %0d link_up too soon after PMA reset", p);
  end

endmodule

`default_nettype wire

// File: verilog/xaui_rx_infra.sv
`default_nettype none

module xaui_rx_infra
  import xaui_infra_pkg::*;
#(
  parameter int NUM_PORTS  = 2,
  parameter     LANE_STEER = 2'b00
) (
  input  wire logic                                gtx_refclk_bufr,
  input  wire logic                                mgt_reset,
  input  wire gtx_lane_raw_t                       lane_raw [NUM_PORTS*lanes_per_port],
  input  wire logic [NUM_PORTS*lanes_per_port-1:0] rxencommaalign,
  output lane_rx_t                                 lane_rx [NUM_PORTS*lanes_per_port],
  output port_status_t                             port_status [NUM_PORTS],
  output logic [NUM_PORTS*lanes_per_port-1:0]      encommaalign_phys,
  output logic                                     pma_reset
);

  localparam int num_lanes = NUM_PORTS * lanes_per_port;

  // Decoded records still in physical lane order
  lane_rx_t lane_dec [num_lanes];

  pma_reset_seq u_reset_seq (
    .gtx_refclk_bufr (gtx_refclk_bufr),
    .mgt_reset       (mgt_reset),
    .pma_reset       (pma_reset)
  );

  // Decode stage
  lane_status_decode #(
    .NUM_PORTS (NUM_PORTS)
  ) u_decode (
    .gtx_refclk_bufr (gtx_refclk_bufr),
    .pma_reset       (pma_reset),
    .lane_raw        (lane_raw),
    .lane_dec        (lane_dec)
  );

  // Steering stage, compensates for lane crossover at the link partner
  rx_lane_steer #(
    .NUM_PORTS  (NUM_PORTS),
    .LANE_STEER (LANE_STEER)
  ) u_steer (
    .gtx_refclk_bufr   (gtx_refclk_bufr),
    .pma_reset         (pma_reset),
    .lane_dec          (lane_dec),
    .rxencommaalign    (rxencommaalign),
    .lane_rx           (lane_rx),
    .encommaalign_phys (encommaalign_phys)
  );

  // Result stage
  port_status_result #(
    .NUM_PORTS (NUM_PORTS)
  ) u_result (
    .gtx_refclk_bufr (gtx_refclk_bufr),
    .pma_reset       (pma_reset),
    .lane_rx         (lane_rx),
    .port_status     (port_status)
  );

endmodule

`default_nettype wire

// File: testbench/tb_xaui_rx_infra.sv
`default_nettype none

module tb_xaui_rx_infra
  import xaui_infra_pkg::*;
();

  localparam int         num_ports = 2;
  localparam logic [1:0] steer_map = 2'b10;
  localparam int         num_lanes = num_ports * lanes_per_port;

  logic                 gtx_refclk_bufr;
  logic                 mgt_reset;
  gtx_lane_raw_t        lane_raw [num_lanes];
  logic [num_lanes-1:0] rxencommaalign;
  lane_rx_t             lane_rx [num_lanes];
  port_status_t         port_status [num_ports];
  logic [num_lanes-1:0] encommaalign_phys;
  logic                 pma_reset;

  // Reference model state, updated on every rising edge
  int           ref_cnt;
  logic         exp_pma;
  logic         model_checks_on;
  lane_rx_t     rx_hist [num_lanes];
  lane_rx_t     exp_rx [num_lanes];
  port_status_t ps_hist0 [num_ports];
  port_status_t ps_hist1 [num_ports];
  port_status_t exp_ps [num_ports];

  logic [31:0] lfsr_state;

  xaui_rx_infra #(
    .NUM_PORTS  (num_ports),
    .LANE_STEER (steer_map)
  ) dut0 (
    .gtx_refclk_bufr   (gtx_refclk_bufr),
    .mgt_reset         (mgt_reset),
    .lane_raw          (lane_raw),
    .rxencommaalign    (rxencommaalign),
    .lane_rx           (lane_rx),
    .port_status       (port_status),
    .encommaalign_phys (encommaalign_phys),
    .pma_reset         (pma_reset)
  );

  always #2 gtx_refclk_bufr = ~gtx_refclk_bufr;

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Physical lane that feeds logical lane k of a port
  function automatic int phys_lane(input int port, input int k);
    if (steer_map[port]) begin
      return port * lanes_per_port + 3 - k;
    end
    return port * lanes_per_port + k;
  endfunction

  function automatic lane_rx_t expect_lane(input gtx_lane_raw_t r);
    lane_rx_t d;
    d.data         = r.data;
    d.charisk      = r.charisk;
    d.comma        = r.comma;
    d.codevalid[0] = !(r.disperr[0] || r.notintable[0]);
    d.codevalid[1] = !(r.disperr[1] || r.notintable[1]);
    d.syncok       = r.lossofsync[1];
    d.bufferr      = r.bufstatus;
    d.elecidle     = r.elecidle;
    d.lock         = r.lock;
    return d;
  endfunction

  // A PMA reset seen at an edge flushes every sample still in the pipeline
  always @(posedge gtx_refclk_bufr) begin : ref_model
    lane_rx_t     cand_rx [num_lanes];
    port_status_t cand_ps [num_ports];
    logic         pma_now;
    logic         all_good;
    logic [3:0]   buf_bits;
    logic [3:0]   idle_bits;
    pma_now = (ref_cnt != 0);
    if (mgt_reset) begin
      ref_cnt = pma_hold_cycles + 1;
    end else if (ref_cnt != 0) begin
      ref_cnt = ref_cnt - 1;
    end
    for (int p = 0; p < num_ports; p++) begin
      all_good = 1'b1;
      for (int k = 0; k < lanes_per_port; k++) begin
        cand_rx[p*lanes_per_port + k] = expect_lane(lane_raw[phys_lane(p, k)]);
        buf_bits[k]  = cand_rx[p*lanes_per_port + k].bufferr;
        idle_bits[k] = cand_rx[p*lanes_per_port + k].elecidle;
        all_good = all_good && cand_rx[p*lanes_per_port + k].syncok
                   && cand_rx[p*lanes_per_port + k].lock
                   && (cand_rx[p*lanes_per_port + k].codevalid == 2'b11);
      end
      cand_ps[p].status  = {4'b0000, buf_bits, 4'b0000, idle_bits};
      cand_ps[p].link_up = all_good;
    end
    for (int l = 0; l < num_lanes; l++) begin
      exp_rx[l]  = pma_now ? '0 : rx_hist[l];
      rx_hist[l] = pma_now ? '0 : cand_rx[l];
    end
    for (int p = 0; p < num_ports; p++) begin
      exp_ps[p]   = pma_now ? '0 : ps_hist1[p];
      ps_hist1[p] = pma_now ? '0 : ps_hist0[p];
      ps_hist0[p] = pma_now ? '0 : cand_ps[p];
    end
    exp_pma = (ref_cnt != 0);
  end

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    assert (got === expected) else begin
      $display("[ERROR] time %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
      abort_run();
    end
  endtask

  // Outputs are sampled on the falling edge, before new inputs are driven
  task automatic next_cycle();
    @(negedge gtx_refclk_bufr);
    if (model_checks_on) begin
      check_value("pma_reset", 64'(pma_reset), 64'(exp_pma));
      for (int l = 0; l < num_lanes; l++) begin
        check_value($sformatf("lane_rx[%0d]", l), 64'(lane_rx[l]), 64'(exp_rx[l]));
      end
      for (int p = 0; p < num_ports; p++) begin
        check_value($sformatf("port_status[%0d]", p), 64'(port_status[p]), 64'(exp_ps[p]));
      end
    end
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      next_cycle();
    end
  endtask

  task automatic check_outputs_zero();
    for (int l = 0; l < num_lanes; l++) begin
      check_value($sformatf("lane_rx[%0d]", l), 64'(lane_rx[l]), 64'(0));
    end
    for (int p = 0; p < num_ports; p++) begin
      check_value($sformatf("port_status[%0d]", p), 64'(port_status[p]), 64'(0));
    end
  endtask

  // Counts edges from the release of mgt_reset until pma_reset is low
  task automatic wait_pma_release(output int edges);
    edges = 0;
    while (pma_reset && edges < 32) begin
      next_cycle();
      edges++;
      check_outputs_zero();
    end
    if (pma_reset) begin
      $display("Timed out waiting for pma_reset to fall after %0d cycles", edges);
      abort_run();
    end
  endtask

  task automatic drive_random_lanes();
    for (int l = 0; l < num_lanes; l++) begin
      lane_raw[l].data       = 16'(take_bits(16));
      lane_raw[l].charisk    = 2'(take_bits(2));
      lane_raw[l].comma      = 2'(take_bits(2));
      lane_raw[l].disperr    = 2'(take_bits(2));
      lane_raw[l].notintable = 2'(take_bits(2));
      lane_raw[l].lossofsync = 2'(take_bits(2));
      lane_raw[l].bufstatus  = 1'(take_bits(1));
      lane_raw[l].elecidle   = 1'(take_bits(1));
      lane_raw[l].lock       = 1'(take_bits(1));
    end
  endtask

  // Locked, in sync and free of code errors on every lane
  task automatic drive_good_lanes();
    for (int l = 0; l < num_lanes; l++) begin
      lane_raw[l].data       = 16'(take_bits(16));
      lane_raw[l].charisk    = 2'(take_bits(2));
      lane_raw[l].comma      = 2'(take_bits(2));
      lane_raw[l].disperr    = 2'b00;
      lane_raw[l].notintable = 2'b00;
      lane_raw[l].lossofsync = 2'b10;
      lane_raw[l].bufstatus  = 1'(take_bits(1));
      lane_raw[l].elecidle   = 1'(take_bits(1));
      lane_raw[l].lock       = 1'b1;
    end
  endtask

  task automatic check_link(input logic [num_ports-1:0] expected);
    for (int p = 0; p < num_ports; p++) begin
      check_value($sformatf("port_status[%0d].link_up", p),
                  64'(port_status[p].link_up), 64'(expected[p]));
    end
  endtask

  task automatic test_reset_timing();
    int edges;
    mgt_reset = 1'b1;
    for (int c = 0; c < 10; c++) begin
      next_cycle();
      // The pipeline is fully cleared two edges into the reset
      if (c == 2) begin
        model_checks_on = 1'b1;
      end
      drive_random_lanes();
    end
    mgt_reset = 1'b0;
    wait_pma_release(edges);
    check_value("pma_reset edges after release", 64'(edges - 1), 64'(pma_hold_cycles));
  endtask

  task automatic test_decode();
    gtx_lane_raw_t held [lanes_per_port];
    logic [1:0]    exp_cv;
    for (int it = 0; it < 24; it++) begin
      drive_random_lanes();
      for (int k = 0; k < lanes_per_port; k++) begin
        held[k] = lane_raw[k];
      end
      wait_cycles(2);
      for (int k = 0; k < lanes_per_port; k++) begin
        // A byte is valid only when neither of its error flags is raised
        for (int i = 0; i < 2; i++) begin
          exp_cv[i] = !(held[k].disperr[i] || held[k].notintable[i]);
        end
        check_value($sformatf("lane_rx[%0d].codevalid", k),
                    64'(lane_rx[k].codevalid), 64'(exp_cv));
        check_value($sformatf("lane_rx[%0d].syncok", k),
                    64'(lane_rx[k].syncok), 64'(held[k].lossofsync[1]));
      end
    end
  endtask

  task automatic test_steering();
    logic [num_lanes-1:0] en;
    logic [15:0]          exp_data;
    drive_random_lanes();
    for (int l = 0; l < num_lanes; l++) begin
      lane_raw[l].data = 16'h0a00 + 16'(l);
    end
    wait_cycles(2);
    for (int p = 0; p < num_ports; p++) begin
      for (int k = 0; k < lanes_per_port; k++) begin
        exp_data = 16'h0a00 + 16'(phys_lane(p, k));
        check_value($sformatf("lane_rx[%0d].data", p*lanes_per_port + k),
                    64'(lane_rx[p*lanes_per_port + k].data), 64'(exp_data));
      end
    end
    // The comma-align path has no register, so it settles within the cycle
    for (int it = 0; it < 8; it++) begin
      en = 8'(take_bits(8));
      rxencommaalign = en;
      #1;
      for (int p = 0; p < num_ports; p++) begin
        for (int k = 0; k < lanes_per_port; k++) begin
          check_value($sformatf("encommaalign_phys[%0d]", phys_lane(p, k)),
                      64'(encommaalign_phys[phys_lane(p, k)]), 64'(en[p*lanes_per_port + k]));
        end
      end
      next_cycle();
    end
  endtask

  task automatic test_status_word();
    logic [16*num_ports-1:0] words [$];
    logic [16*num_ports-1:0] w;
    logic [3:0]              buf_bits;
    logic [3:0]              idle_bits;
    for (int i = 0; i < 22; i++) begin
      if (i < 20) begin
        drive_random_lanes();
        for (int p = 0; p < num_ports; p++) begin
          for (int k = 0; k < lanes_per_port; k++) begin
            buf_bits[k]  = lane_raw[phys_lane(p, k)].bufstatus;
            idle_bits[k] = lane_raw[phys_lane(p, k)].elecidle;
          end
          w[16*p +: 16] = {4'b0000, buf_bits, 4'b0000, idle_bits};
        end
        words.push_back(w);
      end
      next_cycle();
      // Three samples are in flight, so each word shows up three edges later
      if (i >= 2) begin
        w = words.pop_front();
        for (int p = 0; p < num_ports; p++) begin
          check_value($sformatf("port_status[%0d].status", p),
                      64'(port_status[p].status), 64'(w[16*p +: 16]));
        end
      end
    end
  endtask

  task automatic test_link_up();
    logic [num_ports-1:0] exp_link;
    drive_good_lanes();
    wait_cycles(3);
    check_link(2'b11);
    for (int l = 0; l < num_lanes; l++) begin
      for (int c = 0; c < 4; c++) begin
        drive_good_lanes();
        case (c)
          0: lane_raw[l].lock = 1'b0;
          1: lane_raw[l].lossofsync = 2'b01;
          2: lane_raw[l].disperr[l % 2] = 1'b1;
          default: lane_raw[l].notintable[(l + 1) % 2] = 1'b1;
        endcase
        wait_cycles(3);
        exp_link = 2'b11;
        exp_link[l / lanes_per_port] = 1'b0;
        check_link(exp_link);
        drive_good_lanes();
        wait_cycles(3);
        check_link(2'b11);
      end
    end
  endtask

  task automatic test_mid_reset();
    int edges;
    int waited;
    for (int c = 0; c < 6; c++) begin
      drive_random_lanes();
      next_cycle();
    end
    mgt_reset = 1'b1;
    for (int c = 0; c < 4; c++) begin
      next_cycle();
      drive_random_lanes();
    end
    check_value("pma_reset", 64'(pma_reset), 64'(1));
    check_outputs_zero();
    mgt_reset = 1'b0;
    wait_pma_release(edges);
    check_value("pma_reset edges after second release", 64'(edges - 1),
                64'(pma_hold_cycles));
    drive_good_lanes();
    waited = 0;
    while (!(port_status[0].link_up && port_status[1].link_up) && waited < 16) begin
      next_cycle();
      waited++;
    end
    if (!(port_status[0].link_up && port_status[1].link_up)) begin
      $display("Timed out waiting for link_up on both ports after the second reset");
      abort_run();
    end
    for (int c = 0; c < 12; c++) begin
      drive_random_lanes();
      next_cycle();
    end
  endtask

  initial begin
    gtx_refclk_bufr = 1'b0;
    mgt_reset       = 1'b1;
    rxencommaalign  = '0;
    lfsr_state      = 32'h5aa8bbf5;
    ref_cnt         = pma_hold_cycles + 1;
    exp_pma         = 1'b1;
    model_checks_on = 1'b0;
    for (int l = 0; l < num_lanes; l++) begin
      lane_raw[l] = '0;
      rx_hist[l]  = '0;
      exp_rx[l]   = '0;
    end
    for (int p = 0; p < num_ports; p++) begin
      ps_hist0[p] = '0;
      ps_hist1[p] = '0;
      exp_ps[p]   = '0;
    end
    @(posedge gtx_refclk_bufr);
    test_reset_timing();
    test_decode();
    test_steering();
    test_status_word();
    test_link_up();
    test_mid_reset();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
verilog/xaui_infra_pkg.sv
verilog/pma_reset_seq.sv
verilog/lane_status_decode.sv
verilog/rx_lane_steer.sv
verilog/port_status_result.sv
verilog/xaui_rx_infra.sv
testbench/tb_xaui_rx_infra.sv

// File: run_sim.sh
#!/bin/sh
# Builds the XAUI receive infrastructure testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_xaui_rx_infra \
  --Mdir obj_dir \
  -o sim_tb_xaui_rx_infra \
  -f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb_xaui_rx_infra
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
